// ==== all.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

// ==== hdl/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural register count and index width
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// byte distance between consecutive instructions
`define INSTR_STEP 32'h0000_0004

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

        typedef logic [`XLEN-1:0] word_t;
        typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

        // major opcodes handled by this core
        typedef enum logic [6:0] {
                OPC_OP     = 7'b0110011,
                OPC_OP_IMM = 7'b0010011,
                OPC_LUI    = 7'b0110111,
                OPC_BRANCH = 7'b1100011,
                OPC_JAL    = 7'b1101111
        } opcode_e;

        typedef enum logic [3:0] {
                ALU_ADD    = 4'd0,
                ALU_SUB    = 4'd1,
                ALU_SLT    = 4'd2,
                ALU_XOR    = 4'd3,
                ALU_OR     = 4'd4,
                ALU_AND    = 4'd5,
                ALU_SLL    = 4'd6,
                ALU_SRL    = 4'd7,
                ALU_PASS_B = 4'd8
        } alu_op_e;

        typedef struct packed {
                logic    rd_write;
                alu_op_e alu_op;
                logic    src2_imm;
                logic    branch;
                logic    branch_ne;
                logic    jump;
        } ctrl_t;

        typedef struct packed {
                word_t pc;
                word_t instr;
        } if_id_t;

        typedef struct packed {
                word_t     pc;
                reg_addr_t rs1;
                reg_addr_t rs2;
                word_t     rs1_data;
                word_t     rs2_data;
                word_t     imm;
                reg_addr_t rd;
                ctrl_t     ctrl;
        } id_ex_t;

        typedef struct packed {
                logic      rd_write;
                reg_addr_t rd;
                word_t     rd_data;
                logic      redirect;
                word_t     target;
        } ex_mem_t;

        // retired register write, also the core's writeback port
        typedef struct packed {
                logic      write;
                reg_addr_t rd;
                word_t     data;
        } wb_t;

endpackage

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
        input  logic           clk_i,
        input  logic           rst_i,
        output cpu_pkg::word_t imem_addr_o,
        input  cpu_pkg::word_t imem_data_i,
        output cpu_pkg::wb_t   wb_o
);

        import cpu_pkg::*;

        word_t     pc;
        if_id_t    if_id_d;
        if_id_t    if_id_q;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        id_ex_t    id_ex_d;
        id_ex_t    id_ex_q;
        ex_mem_t   ex_mem_d;
        ex_mem_t   ex_mem_q;
        wb_t       mem_wb_d;
        wb_t       mem_wb_q;
        logic      redirect;

        // taken branch or jal sitting in the memory stage
        assign redirect = ex_mem_q.redirect;

        fetch_stage u_fetch (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .redirect_i (redirect),
                .target_i   (ex_mem_q.target),
                .pc_o       (pc)
        );

        assign imem_addr_o = pc;
        assign if_id_d = '{pc: pc, instr: imem_data_i};

        pipe_reg #(.payload_t(if_id_t)) u_if_id (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .clear_i (redirect),
                .d_i     (if_id_d),
                .q_o     (if_id_q)
        );

        decoder u_decoder (
                .if_id_i    (if_id_q),
                .rs1_o      (rs1),
                .rs2_o      (rs2),
                .id_ex_o    (id_ex_d),
                .rs1_data_i (rs1_data),
                .rs2_data_i (rs2_data)
        );

        reg_file u_reg_file (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .rs1_i      (rs1),
                .rs2_i      (rs2),
                .rs1_data_o (rs1_data),
                .rs2_data_o (rs2_data),
                .wb_i       (mem_wb_q)
        );

        pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .clear_i (redirect),
                .d_i     (id_ex_d),
                .q_o     (id_ex_q)
        );

        execute_stage u_execute (
                .id_ex_i   (id_ex_q),
                .mem_fwd_i (ex_mem_q),
                .wb_fwd_i  (mem_wb_q),
                .ex_mem_o  (ex_mem_d)
        );

        // the oldest squashed instruction is still in execute
        pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .clear_i (redirect),
                .d_i     (ex_mem_d),
                .q_o     (ex_mem_q)
        );

        assign mem_wb_d = '{write: ex_mem_q.rd_write, rd: ex_mem_q.rd, data: ex_mem_q.rd_data};

        pipe_reg #(.payload_t(wb_t)) u_mem_wb (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .clear_i (1'b0),
                .d_i     (mem_wb_d),
                .q_o     (mem_wb_q)
        );

        assign wb_o = mem_wb_q;

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module decoder (
        input  cpu_pkg::if_id_t   if_id_i,
        output cpu_pkg::reg_addr_t rs1_o,
        output cpu_pkg::reg_addr_t rs2_o,
        output cpu_pkg::id_ex_t   id_ex_o,
        input  cpu_pkg::word_t    rs1_data_i,
        input  cpu_pkg::word_t    rs2_data_i
);

        import cpu_pkg::*;

        word_t     instr;
        opcode_e   opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t rd;
        word_t     imm_i;
        word_t     imm_u;
        word_t     imm_b;
        word_t     imm_j;
        word_t     imm;
        ctrl_t     ctrl;

        assign instr  = if_id_i.instr;
        assign opcode = opcode_e'(instr[6:0]);
        assign funct3 = instr[14:12];
        assign funct7 = instr[31:25];
        assign rd     = instr[11:7];
        assign rs1_o  = instr[19:15];
        assign rs2_o  = instr[24:20];

        assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        assign imm_u = {instr[31:12], 12'b0};
        assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

        always_comb begin
                ctrl = '0;
                imm  = '0;
                case (opcode)
                        OPC_OP: begin
                                ctrl.rd_write = 1'b1;
                                case (funct3)
                                        3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                                        3'b001:  ctrl.alu_op = ALU_SLL;
                                        3'b010:  ctrl.alu_op = ALU_SLT;
                                        3'b100:  ctrl.alu_op = ALU_XOR;
                                        3'b101:  ctrl.alu_op = ALU_SRL;
                                        3'b110:  ctrl.alu_op = ALU_OR;
                                        3'b111:  ctrl.alu_op = ALU_AND;
                                        default: ctrl.rd_write = 1'b0;
                                endcase
                                // only SUB may use the alternate funct7
                                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                                        ctrl.rd_write = 1'b0;
                                end
                        end
                        OPC_OP_IMM: begin
                                ctrl.rd_write = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                imm = imm_i;
                                case (funct3)
                                        3'b000:  ctrl.alu_op = ALU_ADD;
                                        3'b001:  ctrl.alu_op = ALU_SLL;
                                        3'b010:  ctrl.alu_op = ALU_SLT;
                                        3'b100:  ctrl.alu_op = ALU_XOR;
                                        3'b101:  ctrl.alu_op = ALU_SRL;
                                        3'b110:  ctrl.alu_op = ALU_OR;
                                        3'b111:  ctrl.alu_op = ALU_AND;
                                        default: ctrl.rd_write = 1'b0;
                                endcase
                                // shifts by immediate need a zero funct7, SRAI is not handled
                                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0) begin
                                        ctrl.rd_write = 1'b0;
                                end
                        end
                        OPC_LUI: begin
                                ctrl.rd_write = 1'b1;
                                ctrl.src2_imm = 1'b1;
                                ctrl.alu_op   = ALU_PASS_B;
                                imm = imm_u;
                        end
                        OPC_BRANCH: begin
                                imm = imm_b;
                                // beq and bne only
                                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                                        ctrl.branch    = 1'b1;
                                        ctrl.branch_ne = funct3[0];
                                end
                        end
                        OPC_JAL: begin
                                ctrl.rd_write = 1'b1;
                                ctrl.jump     = 1'b1;
                                imm = imm_j;
                        end
                        default: begin
                                ctrl = '0;
                        end
                endcase
                // x0 is never written
                if (rd == '0) begin
                        ctrl.rd_write = 1'b0;
                end
        end

        assign id_ex_o = '{
                pc:       if_id_i.pc,
                rs1:      rs1_o,
                rs2:      rs2_o,
                rs1_data: rs1_data_i,
                rs2_data: rs2_data_i,
                imm:      imm,
                rd:       rd,
                ctrl:     ctrl
        };

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module execute_stage (
        input  cpu_pkg::id_ex_t  id_ex_i,
        input  cpu_pkg::ex_mem_t mem_fwd_i,
        input  cpu_pkg::wb_t     wb_fwd_i,
        output cpu_pkg::ex_mem_t ex_mem_o
);

        import cpu_pkg::*;

        localparam int SHAMT_W = $clog2(`XLEN);

        word_t rs1_val;
        word_t rs2_val;
        word_t op_b;
        word_t alu_res;
        logic  taken;

        // memory stage result is younger, so it is checked first
        function automatic word_t fwd(input reg_addr_t idx, input word_t reg_val);
                word_t val;
                if (idx != '0 && mem_fwd_i.rd_write && mem_fwd_i.rd == idx) begin
                        val = mem_fwd_i.rd_data;
                end else if (idx != '0 && wb_fwd_i.write && wb_fwd_i.rd == idx) begin
                        val = wb_fwd_i.data;
                end else begin
                        val = reg_val;
                end
                return val;
        endfunction

        always_comb begin
                rs1_val = fwd(id_ex_i.rs1, id_ex_i.rs1_data);
                rs2_val = fwd(id_ex_i.rs2, id_ex_i.rs2_data);
        end

        assign op_b = id_ex_i.ctrl.src2_imm ? id_ex_i.imm : rs2_val;

        always_comb begin
                case (id_ex_i.ctrl.alu_op)
                        ALU_ADD:    alu_res = rs1_val + op_b;
                        ALU_SUB:    alu_res = rs1_val - op_b;
                        ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
                        ALU_XOR:    alu_res = rs1_val ^ op_b;
                        ALU_OR:     alu_res = rs1_val | op_b;
                        ALU_AND:    alu_res = rs1_val & op_b;
                        ALU_SLL:    alu_res = rs1_val << op_b[SHAMT_W-1:0];
                        ALU_SRL:    alu_res = rs1_val >> op_b[SHAMT_W-1:0];
                        ALU_PASS_B: alu_res = op_b;
                        default:    alu_res = rs1_val + op_b;
                endcase
        end

        // bne inverts the equality test
        assign taken = id_ex_i.ctrl.branch && ((rs1_val == rs2_val) ^ id_ex_i.ctrl.branch_ne);

        assign ex_mem_o.rd_write = id_ex_i.ctrl.rd_write;
        assign ex_mem_o.rd       = id_ex_i.rd;
        assign ex_mem_o.rd_data  = id_ex_i.ctrl.jump ? id_ex_i.pc + `INSTR_STEP : alu_res;
        assign ex_mem_o.redirect = taken || id_ex_i.ctrl.jump;
        assign ex_mem_o.target   = id_ex_i.pc + id_ex_i.imm;

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module fetch_stage (
        input  logic           clk_i,
        input  logic           rst_i,
        input  logic           redirect_i,
        input  cpu_pkg::word_t target_i,
        output cpu_pkg::word_t pc_o
);

        import cpu_pkg::*;

        word_t next_pc;

        // taken branch or jump from the memory stage wins
        always_comb begin
                if (redirect_i) begin
                        next_pc = target_i;
                end else begin
                        next_pc = pc_o + `INSTR_STEP;
                end
        end

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        pc_o <= `RESET_PC;
                end else begin
                        pc_o <= next_pc;
                end
        end

endmodule

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
        parameter type payload_t = logic [31:0]
) (
        input  logic     clk_i,
        input  logic     rst_i,
        input  logic     clear_i,
        input  payload_t d_i,
        output payload_t q_o
);

        // all-zero payload acts as a bubble
        always_ff @(posedge clk_i) begin
                if (rst_i || clear_i) begin
                        q_o <= '0;
                end else begin
                        q_o <= d_i;
                end
        end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

`include "cpu_params.svh"

module reg_file (
        input  logic               clk_i,
        input  logic               rst_i,
        input  cpu_pkg::reg_addr_t rs1_i,
        input  cpu_pkg::reg_addr_t rs2_i,
        output cpu_pkg::word_t     rs1_data_o,
        output cpu_pkg::word_t     rs2_data_o,
        input  cpu_pkg::wb_t       wb_i
);

        import cpu_pkg::*;

        word_t regs [`REG_COUNT];

        // x0 reads zero, a same-cycle write is passed through
        function automatic word_t read_reg(input reg_addr_t idx);
                word_t val;
                if (idx == '0) begin
                        val = '0;
                end else if (wb_i.write && wb_i.rd == idx) begin
                        val = wb_i.data;
                end else begin
                        val = regs[idx];
                end
                return val;
        endfunction

        always_comb begin
                rs1_data_o = read_reg(rs1_i);
                rs2_data_o = read_reg(rs2_i);
        end

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wb_i.write && wb_i.rd != '0) begin
                        regs[wb_i.rd] <= wb_i.data;
                end
        end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build the simulation binary with assertions enabled
verilator --binary --assert -f all.f --top-module cpu_tb -o cpu_tb_sim

./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
        echo "simulation reported a failure"
        exit 1
fi
echo "simulation finished without failure"

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

        import cpu_pkg::*;

        localparam int ROM_WORDS = 64;
        localparam int ROM_AW = $clog2(ROM_WORDS);
        localparam int EXP_MAX = 32;
        localparam int RESET_CYCLES = 16;
        localparam int PIPE_FILL = 4;
        localparam int TAIL_CYCLES = 8;

        logic      clk;
        logic      rst;
        word_t     imem_addr;
        word_t     imem_data;
        wb_t       wb;

        word_t     rom [ROM_WORDS];
        reg_addr_t exp_rd [EXP_MAX];
        word_t     exp_data [EXP_MAX];
        int        prog_len = 0;
        int        exp_total = 0;
        int        exp_idx = 0;
        int        cyc = 0;
        int        run_cyc = 0;
        int        tail_cyc = 0;
        int        timeout_cycles = 0;

        cpu_top u_dut (
                .clk_i       (clk),
                .rst_i       (rst),
                .imem_addr_o (imem_addr),
                .imem_data_i (imem_data),
                .wb_o        (wb)
        );

        initial begin
                clk = 1'b0;
        end

        always #5 clk = ~clk;

        // instruction memory answers in the same cycle
        assign imem_data = rom[imem_addr[ROM_AW+1:2]];

        function automatic word_t rr_instr(input logic [6:0] f7, input logic [2:0] f3,
                        input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
                return {f7, rs2, rs1, f3, rd, OPC_OP};
        endfunction

        function automatic word_t imm_instr(input logic [2:0] f3, input reg_addr_t rd,
                        input reg_addr_t rs1, input logic [11:0] imm);
                return {imm, rs1, f3, rd, OPC_OP_IMM};
        endfunction

        function automatic word_t lui_instr(input reg_addr_t rd, input logic [19:0] imm);
                return {imm, rd, OPC_LUI};
        endfunction

        function automatic word_t branch_instr(input logic [2:0] f3, input reg_addr_t rs1,
                        input reg_addr_t rs2, input logic [12:0] off);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
        endfunction

        function automatic word_t jal_instr(input reg_addr_t rd, input logic [20:0] off);
                return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        endfunction

        // appends a program word and its expected write
        task automatic place(input word_t instr, input logic retires, input word_t data);
                rom[prog_len] = instr;
                prog_len++;
                if (retires) begin
                        exp_rd[exp_total] = instr[11:7];
                        exp_data[exp_total] = data;
                        exp_total++;
                end
        endtask

        task automatic load_program();
                for (int i = 0; i < ROM_WORDS; i++) begin
                        // filler writes its own byte address to x31
                        rom[i] = imm_instr(3'b000, 5'd31, 5'd0, 12'(i * 4));
                end
                // producers and consumers at distances 1, 2 and 3
                place(imm_instr(3'b000, 5'd1, 5'd0, 12'd5), 1'b1, 32'h0000_0005);
                place(imm_instr(3'b000, 5'd2, 5'd1, 12'd3), 1'b1, 32'h0000_0008);
                place(imm_instr(3'b000, 5'd3, 5'd0, 12'hfff), 1'b1, 32'hffff_ffff);
                place(rr_instr(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), 1'b1, 32'h0000_000d);
                place(rr_instr(7'h20, 3'b000, 5'd5, 5'd4, 5'd1), 1'b1, 32'h0000_0008);
                // slt, xor, or, and, sll, srl
                place(rr_instr(7'h00, 3'b010, 5'd6, 5'd3, 5'd1), 1'b1, 32'h0000_0001);
                place(rr_instr(7'h00, 3'b010, 5'd7, 5'd1, 5'd3), 1'b1, 32'h0000_0000);
                place(rr_instr(7'h00, 3'b100, 5'd8, 5'd4, 5'd2), 1'b1, 32'h0000_0005);
                place(rr_instr(7'h00, 3'b110, 5'd9, 5'd4, 5'd1), 1'b1, 32'h0000_000d);
                place(rr_instr(7'h00, 3'b111, 5'd10, 5'd4, 5'd2), 1'b1, 32'h0000_0008);
                place(rr_instr(7'h00, 3'b001, 5'd11, 5'd1, 5'd1), 1'b1, 32'h0000_00a0);
                place(rr_instr(7'h00, 3'b101, 5'd12, 5'd3, 5'd1), 1'b1, 32'h07ff_ffff);
                // immediate forms
                place(imm_instr(3'b010, 5'd13, 5'd3, 12'd0), 1'b1, 32'h0000_0001);
                place(imm_instr(3'b100, 5'd14, 5'd1, 12'h0f4), 1'b1, 32'h0000_00f1);
                // ori takes a sign-extended immediate
                place(imm_instr(3'b110, 5'd15, 5'd1, 12'hff4), 1'b1, 32'hffff_fff5);
                place(imm_instr(3'b111, 5'd16, 5'd3, 12'h7ff), 1'b1, 32'h0000_07ff);
                place(imm_instr(3'b001, 5'd17, 5'd1, 12'd28), 1'b1, 32'h5000_0000);
                place(imm_instr(3'b101, 5'd18, 5'd17, 12'd4), 1'b1, 32'h0500_0000);
                place(lui_instr(5'd19, 20'h12345), 1'b1, 32'h1234_5000);
                // x0 as destination and right away as a source
                place(imm_instr(3'b000, 5'd0, 5'd1, 12'd7), 1'b0, 32'h0);
                place(rr_instr(7'h00, 3'b000, 5'd20, 5'd0, 5'd1), 1'b1, 32'h0000_0005);
                // beq falls through and bne is taken on a forwarded x21
                place(branch_instr(3'b000, 5'd1, 5'd2, 13'd8), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd21, 5'd0, 12'h021), 1'b1, 32'h0000_0021);
                place(branch_instr(3'b001, 5'd21, 5'd0, 13'd16), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd22, 5'd0, 12'h0aa), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd23, 5'd0, 12'h0bb), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd24, 5'd0, 12'h0cc), 1'b0, 32'h0);
                // x2 and x5 both hold 8
                place(branch_instr(3'b000, 5'd2, 5'd5, 13'd16), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd22, 5'd0, 12'h0dd), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd23, 5'd0, 12'h0ee), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd24, 5'd0, 12'h0ff), 1'b0, 32'h0);
                // jal at 0x7c links 0x80
                place(jal_instr(5'd25, 21'd16), 1'b1, 32'h0000_0080);
                place(imm_instr(3'b000, 5'd22, 5'd0, 12'h111), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd23, 5'd0, 12'h122), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd24, 5'd0, 12'h133), 1'b0, 32'h0);
                place(imm_instr(3'b000, 5'd26, 5'd25, 12'd1), 1'b1, 32'h0000_0081);
                // park on a jump to itself
                place(jal_instr(5'd0, 21'd0), 1'b0, 32'h0);
        endtask

        task automatic fail_now(input string what);
                $display("%s", what);
                $display("Result: FAILED");
                $fatal(1, "stopped at first error");
        endtask

        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (!rst) begin
                        run_cyc <= run_cyc + 1;
                end
                if (!rst && wb.write && exp_idx < exp_total) begin
                        exp_idx <= exp_idx + 1;
                end
                if (!rst && exp_idx == exp_total) begin
                        tail_cyc <= tail_cyc + 1;
                end
        end

        reset_quiet: assert property (@(posedge clk) rst && cyc > 0 |-> !wb.write)
                else fail_now($sformatf("Error: wb_o.write expected 0x0 got 0x%0h in reset",
                        $sampled(wb.write)));

        reset_pc: assert property (@(posedge clk) rst && cyc > 0 |-> imem_addr == 32'h0)
                else fail_now($sformatf("Error: imem_addr_o expected 0x0 got 0x%0h in reset",
                        $sampled(imem_addr)));

        // first fetch lands on wb_o exactly four cycles later
        first_write: assert property (@(posedge clk)
                !rst && run_cyc <= PIPE_FILL |-> wb.write == (run_cyc == PIPE_FILL))
                else fail_now($sformatf("Error: wb_o.write expected 0x%0h got 0x%0h at cycle %0d",
                        $sampled(run_cyc == PIPE_FILL), $sampled(wb.write), $sampled(run_cyc)));

        no_x0_write: assert property (@(posedge clk) !rst && wb.write |-> wb.rd != '0)
                else fail_now("Error: wb_o.rd got 0x0 while wb_o.write is set");

        extra_write: assert property (@(posedge clk) !rst && wb.write |-> exp_idx < exp_total)
                else fail_now($sformatf("write to x%0d after all %0d expected writes",
                        $sampled(wb.rd), $sampled(exp_total)));

        rd_match: assert property (@(posedge clk)
                !rst && wb.write && exp_idx < exp_total |-> wb.rd == exp_rd[exp_idx])
                else fail_now($sformatf("Error: wb_o.rd expected 0x%0h got 0x%0h at write %0d",
                        $sampled(exp_rd[exp_idx]), $sampled(wb.rd), $sampled(exp_idx)));

        data_match: assert property (@(posedge clk)
                !rst && wb.write && exp_idx < exp_total |-> wb.data == exp_data[exp_idx])
                else fail_now($sformatf("Error: wb_o.data expected 0x%0h got 0x%0h at write %0d",
                        $sampled(exp_data[exp_idx]), $sampled(wb.data), $sampled(exp_idx)));

        initial begin
                rst <= 1'b1;
                load_program();
                // squashed slots already sit in the program words
                timeout_cycles = 3 * (prog_len + PIPE_FILL + TAIL_CYCLES);
                repeat (RESET_CYCLES) @(posedge clk);
                rst <= 1'b0;
                while (tail_cyc < TAIL_CYCLES && run_cyc < timeout_cycles) begin
                        @(negedge clk);
                end
                if (tail_cyc >= TAIL_CYCLES) begin
                        $display("Result: PASSED");
                        $finish;
                end else begin
                        fail_now($sformatf("timeout: only %0d of %0d writes after %0d cycles",
                                exp_idx, exp_total, run_cyc));
                end
        end

endmodule
